// ==== masku_top.f ====
+incdir+verilog
verilog/masku_pkg.sv
verilog/masku_result_queue.sv
verilog/masku_alu.sv
verilog/masku_insn_ctrl.sv
verilog/masku_top.sv
verif/masku_assert.sv
verif/masku_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the mask unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module masku_tb -f masku_top.f -o masku_sim

status=0
./obj_dir/masku_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF ">>> FAIL" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation stopped with status $status"
  exit "$status"
fi
if ! grep -qF ">>> PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== verif/masku_assert.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit protocol checks
// Reset state, request and done handshakes and result hold under
// back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "masku_defs.svh"

module masku_assert (
  input wire logic                                       clk_i,
  input wire logic                                       rst_ni,
  input wire logic                                       req_valid_i,
  input wire logic                                       req_ready_i,
  input wire logic                                       done_i,
  input wire logic [`MASKU_NR_LANES-1:0]                 opa_ready_i,
  input wire logic [`MASKU_NR_LANES-1:0]                 opb_ready_i,
  input wire logic [`MASKU_NR_LANES-1:0]                 result_req_i,
  input wire logic [`MASKU_NR_LANES-1:0]                 result_gnt_i,
  input wire masku_pkg::vaddr_t [`MASKU_NR_LANES-1:0]    result_addr_i,
  input wire masku_pkg::vid_t [`MASKU_NR_LANES-1:0]      result_id_i,
  input wire masku_pkg::elen_t [`MASKU_NR_LANES-1:0]     result_wdata_i,
  input wire masku_pkg::strb_t [`MASKU_NR_LANES-1:0]     result_be_i
);

  // Failed checks so far, summed into the closing report
  int fail_count = 0;

  // Unit idle while reset is held
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> req_ready_i && !done_i && (result_req_i == '0) &&
                (opa_ready_i == '0) && (opb_ready_i == '0))
    else begin
      fail_count++;
      $error("outputs not idle during reset");
    end

  // Ready drops on acceptance and stays low until done
  a_ready_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_ready_i) |=> !req_ready_i)
    else begin
      fail_count++;
      $error("request ready still high after acceptance");
    end

  a_ready_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!req_ready_i && !done_i) |=> !req_ready_i)
    else begin
      fail_count++;
      $error("request ready rose before the done pulse");
    end

  // Done is a single cycle pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done held for more than one cycle");
    end

  // Unit takes new requests right after the pulse
  a_done_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> req_ready_i)
    else begin
      fail_count++;
      $error("request ready stayed low after the done pulse");
    end

  // Pending write held stable until granted
  for (genvar l = 0; l < `MASKU_NR_LANES; l++) begin : g_lane
    a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (result_req_i[l] && !result_gnt_i[l]) |=>
        result_req_i[l] && $stable(result_addr_i[l]) && $stable(result_id_i[l]) &&
        $stable(result_wdata_i[l]) && $stable(result_be_i[l]))
      else begin
        fail_count++;
        $error("lane %0d result changed while waiting for its grant", l);
      end
  end

endmodule

bind masku_top masku_assert u_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .req_ready_i    (req_ready_o),
  .done_i         (done_o),
  .opa_ready_i    (opa_ready_o),
  .opb_ready_i    (opb_ready_o),
  .result_req_i   (result_req_o),
  .result_gnt_i   (result_gnt_i),
  .result_addr_i  (result_addr_o),
  .result_id_i    (result_id_o),
  .result_wdata_i (result_wdata_o),
  .result_be_i    (result_be_o)
);

`default_nettype wire

// ==== verif/masku_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit testbench
// Random lane handshakes, directed and random instructions, and a
// reference model of the merge, address, strobe and count rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "masku_defs.svh"

module masku_tb;

  localparam int NL           = `MASKU_NR_LANES;
  localparam int ELEN         = `MASKU_ELEN;
  localparam int BEAT_BITS    = NL * ELEN;
  localparam int VD_W         = `MASKU_VREG_W;
  localparam int RQ_DEPTH     = `MASKU_RQ_DEPTH;
  localparam int NUM_RANDOM   = 40;
  localparam int ACCEPT_WAIT  = 50;
  localparam int DONE_WAIT    = 2000;
  localparam int STALL_CYCLES = 40;

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  masku_pkg::mask_op_e        req_op;
  masku_pkg::vlen_t           req_vl;
  logic [VD_W-1:0]            req_vd;
  masku_pkg::vid_t            req_id;
  logic                       req_ready;
  logic                       done;
  masku_pkg::vid_t            done_id;
  masku_pkg::vlen_t           done_popcount;
  masku_pkg::elen_t [NL-1:0]  opa;
  masku_pkg::elen_t [NL-1:0]  opb;
  logic [NL-1:0]              opa_valid;
  logic [NL-1:0]              opb_valid;
  logic [NL-1:0]              opa_ready;
  logic [NL-1:0]              opb_ready;
  logic [NL-1:0]              result_req;
  logic [NL-1:0]              result_gnt;
  masku_pkg::vaddr_t [NL-1:0] result_addr;
  masku_pkg::vid_t [NL-1:0]   result_id;
  masku_pkg::elen_t [NL-1:0]  result_wdata;
  masku_pkg::strb_t [NL-1:0]  result_be;

  // Expected writes per lane in arrival order
  masku_pkg::result_payload_t exp_q [NL][$];
  int error_count;
  int words_checked;
  int insn_count;
  bit timed_out;

  masku_top dut (
    .clk_i(clk), .rst_ni(rst_n),
    .req_valid_i(req_valid), .req_op_i(req_op), .req_vl_i(req_vl),
    .req_vd_i(req_vd), .req_id_i(req_id), .req_ready_o(req_ready),
    .done_o(done), .done_id_o(done_id), .done_popcount_o(done_popcount),
    .opa_i(opa), .opa_valid_i(opa_valid), .opa_ready_o(opa_ready),
    .opb_i(opb), .opb_valid_i(opb_valid), .opb_ready_o(opb_ready),
    .result_req_o(result_req), .result_addr_o(result_addr), .result_id_o(result_id),
    .result_wdata_o(result_wdata), .result_be_o(result_be), .result_gnt_i(result_gnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic note_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    error_count++;
  endtask

  // Lane word takes a below vl and old b above with the strobe set by its first bit
  function automatic masku_pkg::result_payload_t expected_write(
      input int beat, input int lane, input masku_pkg::elen_t a, input masku_pkg::elen_t b,
      input int vl, input logic [VD_W-1:0] vd, input masku_pkg::vid_t id);
    masku_pkg::result_payload_t p;
    int base;
    base   = beat * BEAT_BITS + lane * ELEN;
    p.id   = id;
    p.addr = masku_pkg::vaddr_t'(int'(vd) * `MASKU_VREG_WORDS + beat);
    for (int i = 0; i < ELEN; i++) begin
      p.wdata[i] = (base + i < vl) ? a[i] : b[i];
    end
    p.be = (base < vl) ? '1 : '0;
    return p;
  endfunction

  // Set bits of b that sit below vl
  function automatic int count_below_vl(input int beat, input int lane,
                                        input masku_pkg::elen_t b, input int vl);
    int n;
    n = 0;
    for (int i = 0; i < ELEN; i++) begin
      if (b[i] && (beat * BEAT_BITS + lane * ELEN + i < vl)) n++;
    end
    return n;
  endfunction

  // New valids and grants each cycle and fresh operand words after a beat
  task automatic drive_lanes(input int cyc, input int stall_lane, input bit new_data);
    for (int l = 0; l < NL; l++) begin
      opa_valid[l]  = ($urandom_range(7, 0) != 0);
      opb_valid[l]  = ($urandom_range(7, 0) != 0);
      result_gnt[l] = ($urandom_range(1, 0) == 1) && !(l == stall_lane && cyc < STALL_CYCLES);
      if (new_data) begin
        opa[l] = {$urandom, $urandom};
        opb[l] = {$urandom, $urandom};
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One instruction from request to done
  //////////////////////////////////////////////////////////////////////

  task automatic run_insn(input masku_pkg::mask_op_e op, input int vl,
                          input logic [VD_W-1:0] vd, input masku_pkg::vid_t id,
                          input int stall_lane);
    int nbeats;
    int beat;
    int exp_pop;
    int last_fire;
    int last_grant;
    int cyc;
    bit accepted;
    bit finished;
    bit fired;
    masku_pkg::result_payload_t got;
    masku_pkg::result_payload_t exp;
    if (timed_out) return;
    nbeats = (vl + BEAT_BITS - 1) / BEAT_BITS;
    if (nbeats == 0) nbeats = 1;
    req_valid = 1'b1;
    req_op    = op;
    req_vl    = masku_pkg::vlen_t'(vl);
    req_vd    = vd;
    req_id    = id;
    accepted  = 1'b0;
    for (cyc = 0; cyc < ACCEPT_WAIT && !accepted; cyc++) begin
      @(negedge clk);
      accepted = req_ready;
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
    if (!accepted) begin
      $display("Timeout: request id %0d was not accepted in %0d cycles", id, ACCEPT_WAIT);
      timed_out = 1'b1;
      return;
    end
    insn_count++;
    beat       = 0;
    exp_pop    = 0;
    last_fire  = -10;
    last_grant = -10;
    finished   = 1'b0;
    drive_lanes(0, stall_lane, 1'b1);
    for (cyc = 0; cyc < DONE_WAIT && !finished; cyc++) begin
      @(negedge clk);
      // A beat shows as every b ready high
      fired = &opb_ready;
      if (fired) begin
        assert (beat < nbeats) else note_error("beat fired past the last beat");
        assert (op == masku_pkg::MASK_OP_CPOP || &opa_valid)
          else note_error("logical beat fired without every a operand");
        // Writes still waiting in a lane fill its queue
        if (op == masku_pkg::MASK_OP_LOGICAL) begin
          for (int l = 0; l < NL; l++) begin
            assert (exp_q[l].size() < RQ_DEPTH)
              else note_error($sformatf("beat fired while lane %0d queue was full", l));
          end
        end
        for (int l = 0; l < NL; l++) begin
          if (op == masku_pkg::MASK_OP_LOGICAL) begin
            exp_q[l].push_back(expected_write(beat, l, opa[l], opb[l], vl, vd, id));
          end else begin
            exp_pop += count_below_vl(beat, l, opb[l], vl);
          end
        end
        assert (opa_ready == ((op == masku_pkg::MASK_OP_LOGICAL) ? opa_valid : '0))
          else note_error($sformatf("a ready %b on a beat, valid %b", opa_ready, opa_valid));
        beat++;
        last_fire = cyc;
      end else begin
        assert (opa_ready == '0 && opb_ready == '0)
          else note_error($sformatf("partial ready a %b b %b", opa_ready, opb_ready));
      end
      for (int l = 0; l < NL; l++) begin
        if (result_req[l]) begin
          assert (op == masku_pkg::MASK_OP_LOGICAL)
            else note_error($sformatf("lane %0d write request during a count op", l));
          if (result_gnt[l]) begin
            got.id    = result_id[l];
            got.addr  = result_addr[l];
            got.wdata = result_wdata[l];
            got.be    = result_be[l];
            last_grant = cyc;
            if (exp_q[l].size() == 0) begin
              note_error($sformatf("lane %0d wrote with no write expected", l));
            end else begin
              exp = exp_q[l].pop_front();
              words_checked++;
              assert (got == exp) else note_error($sformatf(
                "lane %0d got id %0d addr %0d data %h be %h, expected %0d %0d %h %h",
                l, got.id, got.addr, got.wdata, got.be, exp.id, exp.addr, exp.wdata, exp.be));
            end
          end
        end
      end
      if (done) begin
        finished = 1'b1;
        assert (done_id == id) else note_error($sformatf("done id %0d, expected %0d", done_id, id));
        assert (int'(done_popcount) == exp_pop)
          else note_error($sformatf("popcount %0d, expected %0d", done_popcount, exp_pop));
        assert (beat == nbeats) else note_error($sformatf("%0d beats, expected %0d", beat, nbeats));
        for (int l = 0; l < NL; l++) begin
          assert (exp_q[l].size() == 0)
            else note_error($sformatf("lane %0d done with writes missing", l));
        end
        assert (cyc == ((op == masku_pkg::MASK_OP_LOGICAL) ? last_grant : last_fire) + 1)
          else note_error("done not one cycle after the last grant or beat");
      end
      @(posedge clk);
      #1;
      drive_lanes(cyc + 1, stall_lane, fired);
    end
    if (!finished) begin
      $display("Timeout: instruction id %0d gave no done in %0d cycles", id, DONE_WAIT);
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    masku_pkg::mask_op_e op;
    int vl;
    int stall;
    int assert_fails;
    void'($urandom(32'hf894f08e));
    error_count   = 0;
    words_checked = 0;
    insn_count    = 0;
    timed_out     = 1'b0;
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req_op        = masku_pkg::MASK_OP_LOGICAL;
    req_vl        = '0;
    req_vd        = '0;
    req_id        = '0;
    opa           = '0;
    opb           = '0;
    opa_valid     = '0;
    opb_valid     = '0;
    result_gnt    = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (req_ready && !done && result_req == '0 && opa_ready == '0 && opb_ready == '0)
      else note_error("outputs not idle after reset");
    @(posedge clk);
    #1;
    // Edge cases with a full register, a stalled lane and an empty vl
    run_insn(masku_pkg::MASK_OP_LOGICAL, 1024, 5'd3, 3'd1, 2);
    run_insn(masku_pkg::MASK_OP_CPOP, 0, 5'd7, 3'd2, -1);
    run_insn(masku_pkg::MASK_OP_LOGICAL, 0, 5'd31, 3'd3, -1);
    run_insn(masku_pkg::MASK_OP_CPOP, 1024, 5'd0, 3'd4, 1);
    run_insn(masku_pkg::MASK_OP_LOGICAL, 300, 5'd12, 3'd5, 0);
    for (int n = 0; n < NUM_RANDOM && !timed_out; n++) begin
      op    = ($urandom_range(3, 0) == 0) ? masku_pkg::MASK_OP_CPOP : masku_pkg::MASK_OP_LOGICAL;
      vl    = int'($urandom_range(1024, 1));
      stall = ($urandom_range(1, 0) == 1) ? int'($urandom_range(NL - 1, 0)) : -1;
      run_insn(op, vl, VD_W'($urandom_range(31, 0)), masku_pkg::vid_t'($urandom_range(7, 0)),
               stall);
    end
    assert_fails = dut.u_assert.fail_count;
    $display("Summary: %0d instructions, %0d words checked, %0d errors, %0d %s, timeout %0d",
             insn_count, words_checked, error_count, assert_fails, "assertion failures",
             timed_out);
    if (timed_out || error_count != 0 || assert_fails != 0) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/masku_alu.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit ALU
// Tail bit enable from vl, bitwise merge of the lane operands and
// population count accumulation for count ops
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "masku_defs.svh"

module masku_alu (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire masku_pkg::mask_op_e                     op_i,
  input  wire masku_pkg::vlen_t                        vl_i,
  input  wire masku_pkg::vlen_t                        beat_base_i,
  input  wire logic                                    beat_fire_i,
  input  wire logic                                    start_i,
  input  wire masku_pkg::elen_t [`MASKU_NR_LANES-1:0]  opa_i,
  input  wire masku_pkg::elen_t [`MASKU_NR_LANES-1:0]  opb_i,
  output masku_pkg::elen_t [`MASKU_NR_LANES-1:0]       result_o,
  output masku_pkg::vlen_t                             popcount_o
);

  localparam int BEAT_BITS = `MASKU_NR_LANES * `MASKU_ELEN;

  // Lane l owns bits l*64 to l*64+63 of the beat
  logic [BEAT_BITS-1:0] bit_en;
  logic [BEAT_BITS-1:0] cnt_bits;
  masku_pkg::vlen_t     remain;
  masku_pkg::vlen_t     beat_cnt;
  masku_pkg::vlen_t     acc_q;

  //////////////////////////////////////////////////////////////////////
  // Bit enable
  //////////////////////////////////////////////////////////////////////

  // Bits left under vl from this beat on, zero once past vl
  assign remain = (vl_i > beat_base_i) ? (vl_i - beat_base_i) : '0;

  // Thermometer of the low remain bits, saturates to all ones
  assign bit_en = ~({BEAT_BITS{1'b1}} << remain);

  //////////////////////////////////////////////////////////////////////
  // Merge
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `MASKU_NR_LANES; l++) begin : g_lane
    masku_pkg::elen_t en;
    assign en = bit_en[l*`MASKU_ELEN +: `MASKU_ELEN];

    // New bits from a, tail kept from the old destination b
    assign result_o[l] = (opa_i[l] & en) | (opb_i[l] & ~en);

    // Only enabled bits of b take part in the count
    assign cnt_bits[l*`MASKU_ELEN +: `MASKU_ELEN] = opb_i[l] & en;
  end

  //////////////////////////////////////////////////////////////////////
  // Population count
  //////////////////////////////////////////////////////////////////////

  // At most 256 per beat, fits the 11-bit count
  always_comb begin
    beat_cnt = '0;
    for (int i = 0; i < BEAT_BITS; i++) begin
      beat_cnt = beat_cnt + masku_pkg::vlen_t'(cnt_bits[i]);
    end
  end

  // Running total over all beats of the instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (start_i) begin
      acc_q <= '0;
    end else if (beat_fire_i && (op_i == masku_pkg::MASK_OP_CPOP)) begin
      acc_q <= acc_q + beat_cnt;
    end
  end

  assign popcount_o = acc_q;

endmodule

`default_nettype wire

// ==== verilog/masku_defs.svh ====
//////////////////////////////////////////////////////////////////////
// Mask unit geometry
// Lane count, word widths, result queue depth and register layout
// shared by the mask unit RTL and its testbench
//////////////////////////////////////////////////////////////////////

`ifndef MASKU_DEFS_SVH
`define MASKU_DEFS_SVH

// Number of lanes, each one carries a 64-bit word per beat
`define MASKU_NR_LANES   4
// Lane word width in bits
`define MASKU_ELEN       64
// Byte strobes per lane word
`define MASKU_STRB_W     (`MASKU_ELEN/8)

// Entries in each per-lane result queue
`define MASKU_RQ_DEPTH   2

// Words per vector register in one lane, 4 lanes x 4 words x 64 bits
`define MASKU_VREG_WORDS 4
// Vector length width, counts bits up to 1024
`define MASKU_VL_W       11

// Instruction id, register index and lane VRF address widths
`define MASKU_ID_W       3
`define MASKU_VREG_W     5
`define MASKU_ADDR_W     8

`endif

// ==== verilog/masku_insn_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit instruction control
// Holds the single active instruction, fires operand beats, tracks
// issued and pending beats and raises the done response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "masku_defs.svh"

module masku_insn_ctrl (
  input  wire logic                                            clk_i,
  input  wire logic                                            rst_ni,
  // Sequencer request
  input  wire logic                                            req_valid_i,
  input  wire masku_pkg::mask_op_e                             req_op_i,
  input  wire masku_pkg::vlen_t                                req_vl_i,
  input  wire logic [`MASKU_VREG_W-1:0]                        req_vd_i,
  input  wire masku_pkg::vid_t                                 req_id_i,
  output logic                                                 req_ready_o,
  // Operand handshakes per lane
  input  wire logic [`MASKU_NR_LANES-1:0]                      opa_valid_i,
  input  wire logic [`MASKU_NR_LANES-1:0]                      opb_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                           opa_ready_o,
  output logic [`MASKU_NR_LANES-1:0]                           opb_ready_o,
  // Result queue status per lane
  input  wire logic [`MASKU_NR_LANES-1:0]                      q_full_i,
  input  wire logic [`MASKU_NR_LANES-1:0]                      q_empty_i,
  // Running count from the ALU
  input  wire masku_pkg::vlen_t                                popcount_i,
  // Beat control toward ALU and queues
  output logic                                                 beat_fire_o,
  output masku_pkg::mask_op_e                                  op_o,
  output masku_pkg::vlen_t                                     vl_o,
  output masku_pkg::vlen_t                                     beat_base_o,
  output masku_pkg::vaddr_t                                    addr_o,
  output masku_pkg::vid_t                                      id_o,
  output masku_pkg::strb_t [`MASKU_NR_LANES-1:0]               lane_be_o,
  // Done response
  output logic                                                 done_o,
  output masku_pkg::vid_t                                      done_id_o,
  output masku_pkg::vlen_t                                     done_popcount_o
);

  // Bits covered by one beat over all lanes, 256
  localparam int BEAT_BITS  = `MASKU_NR_LANES * `MASKU_ELEN;
  localparam int BEAT_SHIFT = $clog2(BEAT_BITS);
  // Beat counter must hold a full register worth of beats
  localparam int BCNT_W     = $clog2(`MASKU_VREG_WORDS + 1);
  localparam int VLX_W      = `MASKU_VL_W + 1;

  // Control state
  logic              active_q;
  logic [BCNT_W-1:0] issued_q;
  logic [BCNT_W-1:0] pending_q;

  // Active instruction fields
  masku_pkg::mask_op_e        op_q;
  masku_pkg::vlen_t           vl_q;
  logic [`MASKU_VREG_W-1:0]   vd_q;
  masku_pkg::vid_t            id_q;

  logic              req_fire;
  logic [VLX_W-1:0]  vl_round;
  logic [BCNT_W-1:0] req_beats;
  logic              operands_ok;

  //////////////////////////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////////////////////////

  // Only one instruction in flight
  assign req_ready_o = !active_q;
  assign req_fire    = req_valid_i && req_ready_o;

  // ceil(vl/256) beats, never less than one
  always_comb begin
    vl_round  = {1'b0, req_vl_i} + VLX_W'(BEAT_BITS - 1);
    req_beats = BCNT_W'(vl_round >> BEAT_SHIFT);
    if (req_beats == '0) begin
      req_beats = BCNT_W'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Beat issue
  //////////////////////////////////////////////////////////////////////

  // Count ops read only the old destination, operand a is ignored
  assign operands_ok = (&opb_valid_i) &&
                       ((op_q == masku_pkg::MASK_OP_CPOP) || (&opa_valid_i));

  // A beat needs every lane ready and room in every result queue
  assign beat_fire_o = active_q && (pending_q != '0) && operands_ok && !(|q_full_i);

  assign opb_ready_o = beat_fire_o ? opb_valid_i : '0;
  assign opa_ready_o = (beat_fire_o && (op_q == masku_pkg::MASK_OP_LOGICAL)) ?
                       opa_valid_i : '0;

  assign op_o        = op_q;
  assign vl_o        = vl_q;
  assign id_o        = id_q;
  assign beat_base_o = masku_pkg::vlen_t'(issued_q) << BEAT_SHIFT;

  // Register base of vd, one word per beat
  assign addr_o = masku_pkg::vaddr_t'(vd_q) * masku_pkg::vaddr_t'(`MASKU_VREG_WORDS) +
                  masku_pkg::vaddr_t'(issued_q);

  // Whole-word strobes, a lane writes if its first bit is under vl
  always_comb begin
    for (int l = 0; l < `MASKU_NR_LANES; l++) begin
      lane_be_o[l] = ((beat_base_o + masku_pkg::vlen_t'(l * `MASKU_ELEN)) < vl_q) ? '1 : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////////////////////////

  // All beats out and every lane drained, decoded from registered state
  assign done_o          = active_q && (pending_q == '0) && (&q_empty_i);
  assign done_id_o       = id_q;
  assign done_popcount_o = (op_q == masku_pkg::MASK_OP_CPOP) ? popcount_i : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      issued_q  <= '0;
      pending_q <= '0;
    end else if (req_fire) begin
      active_q  <= 1'b1;
      issued_q  <= '0;
      pending_q <= req_beats;
    end else if (done_o) begin
      active_q  <= 1'b0;
    end else if (beat_fire_o) begin
      issued_q  <= issued_q + BCNT_W'(1);
      pending_q <= pending_q - BCNT_W'(1);
    end
  end

  // Instruction fields, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q <= req_op_i;
      vl_q <= req_vl_i;
      vd_q <= req_vd_i;
      id_q <= req_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/masku_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit types
// Lane words, strobes, ids, addresses, the opcode and the payload
// carried by the per-lane result queues
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "masku_defs.svh"

package masku_pkg;

  // One lane word and its byte enable
  typedef logic [`MASKU_ELEN-1:0]   elen_t;
  typedef logic [`MASKU_STRB_W-1:0] strb_t;

  // Instruction id handed out by the sequencer
  typedef logic [`MASKU_ID_W-1:0] vid_t;

  // Word address inside one lane's register file
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // Bit count, wide enough for a full 1024-bit register
  typedef logic [`MASKU_VL_W-1:0] vlen_t;

  // Supported mask operations
  typedef enum logic {
    MASK_OP_LOGICAL = 1'b0,  // Merge a below vl, keep b above
    MASK_OP_CPOP    = 1'b1   // Count set bits of b below vl
  } mask_op_e;

  // Write request toward one lane's VRF port, 83 bits
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_payload_t;

endpackage

`default_nettype wire

// ==== verilog/masku_result_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Result queue
// Small circular buffer holding lane results until the lane's VRF
// port grants them, payload type set per instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "masku_defs.svh"

module masku_result_queue #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          valid_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int DEPTH = `MASKU_RQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage
  payload_t mem_q [DEPTH];

  // Pointers and occupancy
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic push_ok;
  logic pop_ok;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign valid_o = !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // Overflow and underflow are ignored
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Simultaneous push and pop keep the count
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/masku_top.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit top level
// Instruction control, mask ALU and one result queue per lane
// toward the lane VRF write ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "masku_defs.svh"

module masku_top (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  // Sequencer
  input  wire logic                                      req_valid_i,
  input  wire masku_pkg::mask_op_e                       req_op_i,
  input  wire masku_pkg::vlen_t                          req_vl_i,
  input  wire logic [`MASKU_VREG_W-1:0]                  req_vd_i,
  input  wire masku_pkg::vid_t                           req_id_i,
  output logic                                           req_ready_o,
  output logic                                           done_o,
  output masku_pkg::vid_t                                done_id_o,
  output masku_pkg::vlen_t                               done_popcount_o,
  // Lane operands
  input  wire masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    opa_i,
  input  wire logic [`MASKU_NR_LANES-1:0]                opa_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                     opa_ready_o,
  input  wire masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    opb_i,
  input  wire logic [`MASKU_NR_LANES-1:0]                opb_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                     opb_ready_o,
  // Lane VRF write ports
  output logic [`MASKU_NR_LANES-1:0]                     result_req_o,
  output masku_pkg::vaddr_t [`MASKU_NR_LANES-1:0]        result_addr_o,
  output masku_pkg::vid_t [`MASKU_NR_LANES-1:0]          result_id_o,
  output masku_pkg::elen_t [`MASKU_NR_LANES-1:0]         result_wdata_o,
  output masku_pkg::strb_t [`MASKU_NR_LANES-1:0]         result_be_o,
  input  wire logic [`MASKU_NR_LANES-1:0]                result_gnt_i
);

  // Controller to ALU and queues
  logic                                    beat_fire;
  logic                                    start;
  masku_pkg::mask_op_e                     op;
  masku_pkg::vlen_t                        vl;
  masku_pkg::vlen_t                        beat_base;
  masku_pkg::vaddr_t                       addr;
  masku_pkg::vid_t                         id;
  masku_pkg::strb_t [`MASKU_NR_LANES-1:0]  lane_be;
  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]  alu_result;
  masku_pkg::vlen_t                        popcount;
  logic [`MASKU_NR_LANES-1:0]              q_full;
  logic [`MASKU_NR_LANES-1:0]              q_empty;

  // Accumulator restarts with each accepted instruction
  assign start = req_valid_i && req_ready_o;

  masku_insn_ctrl u_insn_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vl_i, .req_vd_i, .req_id_i, .req_ready_o,
    .opa_valid_i, .opb_valid_i, .opa_ready_o, .opb_ready_o,
    .q_full_i   (q_full),
    .q_empty_i  (q_empty),
    .popcount_i (popcount),
    .beat_fire_o(beat_fire),
    .op_o       (op),
    .vl_o       (vl),
    .beat_base_o(beat_base),
    .addr_o     (addr),
    .id_o       (id),
    .lane_be_o  (lane_be),
    .done_o, .done_id_o, .done_popcount_o
  );

  masku_alu u_alu (
    .clk_i, .rst_ni,
    .op_i       (op),
    .vl_i       (vl),
    .beat_base_i(beat_base),
    .beat_fire_i(beat_fire),
    .start_i    (start),
    .opa_i, .opb_i,
    .result_o   (alu_result),
    .popcount_o (popcount)
  );

  // One queue per lane, pushed only by logical beats
  for (genvar l = 0; l < `MASKU_NR_LANES; l++) begin : g_lane
    masku_pkg::result_payload_t push_data;
    masku_pkg::result_payload_t head;

    assign push_data.id    = id;
    assign push_data.addr  = addr;
    assign push_data.wdata = alu_result[l];
    assign push_data.be    = lane_be[l];

    masku_result_queue #(
      .payload_t(masku_pkg::result_payload_t)
    ) u_result_queue (
      .clk_i, .rst_ni,
      .push_i (beat_fire && (op == masku_pkg::MASK_OP_LOGICAL)),
      .data_i (push_data),
      .pop_i  (result_req_o[l] && result_gnt_i[l]),
      .data_o (head),
      .valid_o(result_req_o[l]),
      .full_o (q_full[l]),
      .empty_o(q_empty[l])
    );

    assign result_id_o[l]    = head.id;
    assign result_addr_o[l]  = head.addr;
    assign result_wdata_o[l] = head.wdata;
    assign result_be_o[l]    = head.be;
  end

endmodule

`default_nettype wire
